/* hdl/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

	typedef logic [63:0] reg_data_t;
	typedef logic [7:0] reg_adr_t;
	typedef logic [7:0] tid_t;
	typedef logic [63:0] address_t;
	typedef logic [15:0] asid_t;
	typedef logic [1:0] region_idx_t;

	localparam int NUM_REGIONS = 4;

	// register map, word addresses
	localparam reg_adr_t ADR_FAULT_ADR = 8'h00;   // read only
	localparam reg_adr_t ADR_FAULT_INFO = 8'h01;  // any write clears valid
	localparam reg_adr_t ADR_PTBR = 8'h02;
	localparam reg_adr_t ADR_PTATTR = 8'h03;
	localparam reg_adr_t ADR_PROBE_VADR = 8'h04;  // write starts a lookup
	localparam reg_adr_t ADR_PROBE_PADR = 8'h05;
	localparam reg_adr_t ADR_PROBE_STAT = 8'h06;
	localparam reg_adr_t ADR_REGION_BASE = 8'h10;
	localparam reg_adr_t ADR_REGION_LAST = ADR_REGION_BASE + 8'(4 * NUM_REGIONS) - 8'd1;

	typedef enum logic [1:0]
	{
		PT_I386 = 2'd0,
		PT_X64 = 2'd1,
		PT_HASHED = 2'd2,
		PT_NONE = 2'd3
	} pt_type_e;

	typedef enum logic [1:0]
	{
		PTE_4B = 2'd0,
		PTE_8B = 2'd1
	} pte_size_e;

	typedef enum logic [1:0]
	{
		IDLE = 2'd0,
		LOOKUP = 2'd1,
		DONE = 2'd2
	} ctrl_state_e;

endpackage

`default_nettype wire

/* hdl/mmu_reg_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface mmu_reg_bus_if;
	import mmu_pkg::*;

	logic acc;          // one cycle per access
	logic we;
	reg_adr_t adr;
	reg_data_t wdat;
	logic sel_fault;
	logic sel_ptreg;
	logic sel_probe;
	logic sel_region;

	modport ctrl
	(
		output acc, we, adr, wdat,
		output sel_fault, sel_ptreg, sel_probe, sel_region
	);

	modport dev
	(
		input acc, we, adr, wdat,
		input sel_fault, sel_ptreg, sel_probe, sel_region
	);

endinterface

`default_nettype wire

/* hdl/mmu_reg_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module mmu_reg_ctrl
(
	input logic clk,
	input logic rst,
	input logic req_cyc,
	input logic req_we,
	input mmu_pkg::reg_adr_t req_adr,
	input mmu_pkg::reg_data_t req_dat,
	input mmu_pkg::tid_t req_tid,
	mmu_reg_bus_if.ctrl bus,
	output logic probe_start,
	input logic probe_done,
	output mmu_pkg::tid_t tid_q
);
	import mmu_pkg::*;

	ctrl_state_e state;
	logic probe_pend;
	logic probe_wr;
	logic dec_fault;
	logic dec_ptreg;
	logic dec_probe;
	logic dec_region;

	always_comb
	begin
		dec_fault = req_adr inside {ADR_FAULT_ADR, ADR_FAULT_INFO};
		dec_ptreg = req_adr inside {ADR_PTBR, ADR_PTATTR};
		dec_probe = req_adr inside {ADR_PROBE_VADR, ADR_PROBE_PADR, ADR_PROBE_STAT};
		dec_region = req_adr inside {[ADR_REGION_BASE:ADR_REGION_LAST]};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bus.acc <= 1'b0;
			bus.sel_fault <= 1'b0;
			bus.sel_ptreg <= 1'b0;
			bus.sel_probe <= 1'b0;
			bus.sel_region <= 1'b0;
		end
		else
		begin
			bus.acc <= req_cyc;
			bus.sel_fault <= req_cyc & dec_fault;
			bus.sel_ptreg <= req_cyc & dec_ptreg;
			bus.sel_probe <= req_cyc & dec_probe;
			bus.sel_region <= req_cyc & dec_region;
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_cyc)
		begin
			bus.we <= req_we;
			bus.adr <= req_adr;
			bus.wdat <= req_dat;
			tid_q <= req_tid;
		end
	end

	assign probe_wr = bus.acc & bus.we & bus.sel_probe & (bus.adr == ADR_PROBE_VADR);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			probe_start <= 1'b0;
			probe_pend <= 1'b0;
		end
		else
		begin
			probe_start <= 1'b0;
			case (state)
			IDLE:
				if (probe_wr)
				begin
					state <= LOOKUP;
					probe_start <= 1'b1;
				end
			LOOKUP:
				if (probe_done)
				begin
					if (probe_pend | probe_wr)
					begin
						probe_start <= 1'b1;  // rerun with newer address
						probe_pend <= 1'b0;
					end
					else
						state <= DONE;
				end
				else if (probe_wr)
					probe_pend <= 1'b1;
			DONE:
				if (probe_wr)
				begin
					state <= LOOKUP;
					probe_start <= 1'b1;
				end
				else
					state <= IDLE;
			default:
				state <= IDLE;
			endcase
		end
	end

	// selects only with acc, never two groups at once
	a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({bus.sel_fault, bus.sel_ptreg, bus.sel_probe, bus.sel_region}) &&
		((bus.sel_fault | bus.sel_ptreg | bus.sel_probe | bus.sel_region) -> bus.acc));

endmodule

`default_nettype wire

/* hdl/mmu_read_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module mmu_read_reg
(
	input logic clk,
	input logic rst,
	mmu_reg_bus_if.dev bus,
	input mmu_pkg::tid_t tid_q,
	input mmu_pkg::address_t fault_adr,
	input mmu_pkg::asid_t fault_asid,
	input logic fault_valid,
	input mmu_pkg::address_t probe_vadr,
	input mmu_pkg::address_t probe_padr,
	input logic probe_hit,
	input mmu_pkg::region_idx_t probe_idx,
	input mmu_pkg::reg_data_t region_rdat,
	output logic resp_ack,
	output mmu_pkg::tid_t resp_tid,
	output mmu_pkg::reg_data_t resp_dat,
	output mmu_pkg::pte_size_e pte_size
);
	import mmu_pkg::*;

	reg_data_t ptbr;
	reg_data_t ptattr;
	reg_data_t rdat;
	pt_type_e wr_type;

	assign wr_type = pt_type_e'(bus.wdat[1:0]);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ptbr <= '0;
			ptattr <= '0;
			pte_size <= PTE_4B;
		end
		else if (bus.acc & bus.we & bus.sel_ptreg)
		begin
			if (bus.adr == ADR_PTBR)
				ptbr <= bus.wdat;
			else if (bus.adr == ADR_PTATTR)
			begin
				ptattr <= bus.wdat;
				pte_size <= (wr_type == PT_I386) ? PTE_4B : PTE_8B;  // track new type
			end
		end
	end

	always_comb
	begin
		rdat = '0;
		if (bus.sel_fault | bus.sel_ptreg | bus.sel_probe)
		begin
			case (bus.adr)
			ADR_FAULT_ADR:  rdat = fault_adr;
			ADR_FAULT_INFO: rdat = {fault_asid, 47'd0, fault_valid};
			ADR_PTBR:       rdat = ptbr;
			ADR_PTATTR:     rdat = ptattr;
			ADR_PROBE_VADR: rdat = probe_vadr;
			ADR_PROBE_PADR: rdat = probe_padr;
			ADR_PROBE_STAT: rdat = {54'd0, probe_idx, 7'd0, probe_hit};
			default:        rdat = '0;
			endcase
		end
		else if (bus.sel_region)
			rdat = region_rdat;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			resp_ack <= 1'b0;
		else
			resp_ack <= bus.acc;
	end

	always_ff @(posedge clk)
	begin
		resp_dat <= '0;
		if (bus.acc)
		begin
			resp_tid <= tid_q;
			if (!bus.we)
				resp_dat <= rdat;  // writes answer with zero
		end
	end

endmodule

`default_nettype wire

/* hdl/mmu_fault_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module mmu_fault_capture
(
	input logic clk,
	input logic rst,
	mmu_reg_bus_if.dev bus,
	input logic fault_stb,
	input mmu_pkg::address_t fault_vadr,
	input mmu_pkg::asid_t fault_asid,
	output mmu_pkg::address_t fault_adr,
	output mmu_pkg::asid_t fault_asid_q,
	output logic fault_valid
);
	import mmu_pkg::*;

	logic clear;

	// any write to the info word rearms the latch
	assign clear = bus.acc & bus.we & bus.sel_fault & (bus.adr == ADR_FAULT_INFO);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			fault_valid <= 1'b0;
			fault_adr <= '0;
			fault_asid_q <= '0;
		end
		else if (clear)
			fault_valid <= 1'b0;  // clear beats a new strobe
		else if (fault_stb & !fault_valid)
		begin
			fault_valid <= 1'b1;
			fault_adr <= fault_vadr;
			fault_asid_q <= fault_asid;
		end
	end

endmodule

`default_nettype wire

/* hdl/mmu_region_table.sv */
`timescale 1ns/100ps
`default_nettype none

module mmu_region_table
(
	input logic clk,
	input logic rst,
	mmu_reg_bus_if.dev bus,
	input logic probe_start,
	output mmu_pkg::address_t probe_vadr,
	output mmu_pkg::reg_data_t region_rdat,
	output mmu_pkg::address_t probe_padr,
	output logic probe_hit,
	output mmu_pkg::region_idx_t probe_idx,
	output logic probe_done
);
	import mmu_pkg::*;

	address_t base [NUM_REGIONS];
	address_t limit [NUM_REGIONS];
	address_t offs [NUM_REGIONS];
	logic [NUM_REGIONS-1:0] en;
	reg_adr_t tbl_off;
	region_idx_t tbl_idx;
	logic [1:0] tbl_word;
	logic [NUM_REGIONS-1:0] match;
	logic any_match;
	region_idx_t match_idx;
	address_t match_padr;

	assign tbl_off = bus.adr - ADR_REGION_BASE;
	assign tbl_idx = tbl_off[3:2];
	assign tbl_word = tbl_off[1:0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_REGIONS; i++)
			begin
				base[i] <= '0;
				limit[i] <= '0;
				offs[i] <= '0;
			end
			en <= '0;
			probe_vadr <= '0;
		end
		else if (bus.acc & bus.we)
		begin
			if (bus.sel_region)
			begin
				case (tbl_word)
				2'd0:    base[tbl_idx] <= bus.wdat;
				2'd1:    limit[tbl_idx] <= bus.wdat;
				2'd2:    offs[tbl_idx] <= bus.wdat;
				default: en[tbl_idx] <= bus.wdat[0];  // rest of word 3 dropped
				endcase
			end
			else if (bus.sel_probe && bus.adr == ADR_PROBE_VADR)
				probe_vadr <= bus.wdat;
		end
	end

	always_comb
	begin
		case (tbl_word)
		2'd0:    region_rdat = base[tbl_idx];
		2'd1:    region_rdat = limit[tbl_idx];
		2'd2:    region_rdat = offs[tbl_idx];
		default: region_rdat = {63'd0, en[tbl_idx]};
		endcase
	end

	always_comb
	begin
		for (int i = 0; i < NUM_REGIONS; i++)
			match[i] = en[i] && (probe_vadr >= base[i]) && (probe_vadr < limit[i]);
	end

	always_comb
	begin
		match_idx = '0;
		for (int i = NUM_REGIONS - 1; i >= 0; i--)
			if (match[i])
				match_idx = region_idx_t'(i);  // lowest index wins
	end

	assign any_match = |match;
	assign match_padr = probe_vadr - base[match_idx] + offs[match_idx];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			probe_hit <= 1'b0;
			probe_idx <= '0;
			probe_padr <= '0;
			probe_done <= 1'b0;
		end
		else
		begin
			probe_done <= probe_start;
			if (probe_start)
			begin
				probe_hit <= any_match;
				probe_idx <= any_match ? match_idx : '0;
				probe_padr <= any_match ? match_padr : '0;
			end
		end
	end

	a_done_single: assert property (@(posedge clk) disable iff (rst)
		probe_done |=> !probe_done);

endmodule

`default_nettype wire

/* hdl/mmu_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module mmu_regs
(
	input logic clk,
	input logic rst,
	input logic req_cyc,
	input logic req_we,
	input mmu_pkg::reg_adr_t req_adr,
	input mmu_pkg::reg_data_t req_dat,
	input mmu_pkg::tid_t req_tid,
	output logic resp_ack,
	output mmu_pkg::reg_data_t resp_dat,
	output mmu_pkg::tid_t resp_tid,
	input logic fault_stb,
	input mmu_pkg::address_t fault_vadr,
	input mmu_pkg::asid_t fault_asid,
	output mmu_pkg::pte_size_e pte_size
);
	import mmu_pkg::*;

	tid_t tid_q;
	logic probe_start;
	logic probe_done;
	address_t fault_adr;
	asid_t fault_asid_q;
	logic fault_valid;
	address_t probe_vadr;
	address_t probe_padr;
	logic probe_hit;
	region_idx_t probe_idx;
	reg_data_t region_rdat;

	mmu_reg_bus_if i_bus ();

	mmu_reg_ctrl i_ctrl
	(
		.clk(clk),
		.rst(rst),
		.req_cyc(req_cyc),
		.req_we(req_we),
		.req_adr(req_adr),
		.req_dat(req_dat),
		.req_tid(req_tid),
		.bus(i_bus.ctrl),
		.probe_start(probe_start),
		.probe_done(probe_done),
		.tid_q(tid_q)
	);

	mmu_read_reg i_read_reg
	(
		.clk(clk),
		.rst(rst),
		.bus(i_bus.dev),
		.tid_q(tid_q),
		.fault_adr(fault_adr),
		.fault_asid(fault_asid_q),
		.fault_valid(fault_valid),
		.probe_vadr(probe_vadr),
		.probe_padr(probe_padr),
		.probe_hit(probe_hit),
		.probe_idx(probe_idx),
		.region_rdat(region_rdat),
		.resp_ack(resp_ack),
		.resp_tid(resp_tid),
		.resp_dat(resp_dat),
		.pte_size(pte_size)
	);

	mmu_fault_capture i_fault
	(
		.clk(clk),
		.rst(rst),
		.bus(i_bus.dev),
		.fault_stb(fault_stb),
		.fault_vadr(fault_vadr),
		.fault_asid(fault_asid),
		.fault_adr(fault_adr),
		.fault_asid_q(fault_asid_q),
		.fault_valid(fault_valid)
	);

	mmu_region_table i_region
	(
		.clk(clk),
		.rst(rst),
		.bus(i_bus.dev),
		.probe_start(probe_start),
		.probe_vadr(probe_vadr),
		.region_rdat(region_rdat),
		.probe_padr(probe_padr),
		.probe_hit(probe_hit),
		.probe_idx(probe_idx),
		.probe_done(probe_done)
	);

endmodule

`default_nettype wire

/* test/tb_mmu_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mmu_regs;
	import mmu_pkg::*;

	localparam int N_UNMAPPED = 12;
	localparam int N_PT_ROUNDS = 2;
	localparam int N_TBL_ROUNDS = 3;
	localparam int N_SETUPS = 3;
	localparam int NUM_TRANS = (7 + 16 + N_UNMAPPED) + 16 * N_PT_ROUNDS
		+ 32 * N_TBL_ROUNDS + N_SETUPS * (16 + 13 * 4) + 6;
	localparam int WATCHDOG_CYCLES = NUM_TRANS * 20 + 500;

	logic clk;
	logic rst;
	logic req_cyc;
	logic req_we;
	reg_adr_t req_adr;
	reg_data_t req_dat;
	tid_t req_tid;
	logic resp_ack;
	reg_data_t resp_dat;
	tid_t resp_tid;
	logic fault_stb;
	address_t fault_vadr;
	asid_t fault_asid;
	pte_size_e pte_size;

	int errors;
	int checks;
	int tests;
	int failed_tests;
	int trans;
	int test_err0;
	tid_t tid_d1;
	tid_t tid_d2;

	// reference model of the register state
	address_t m_base [NUM_REGIONS];
	address_t m_limit [NUM_REGIONS];
	address_t m_offs [NUM_REGIONS];
	logic m_en [NUM_REGIONS];
	reg_data_t m_ptbr;
	reg_data_t m_ptattr;
	address_t m_fault_adr;
	asid_t m_fault_asid;
	logic m_fault_valid;

	mmu_regs i_mmu_regs
	(
		.clk(clk),
		.rst(rst),
		.req_cyc(req_cyc),
		.req_we(req_we),
		.req_adr(req_adr),
		.req_dat(req_dat),
		.req_tid(req_tid),
		.resp_ack(resp_ack),
		.resp_dat(resp_dat),
		.resp_tid(resp_tid),
		.fault_stb(fault_stb),
		.fault_vadr(fault_vadr),
		.fault_asid(fault_asid),
		.pte_size(pte_size)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	always @(posedge clk)
	begin
		tid_d1 <= req_tid;  // ids as seen by the bus, two deep
		tid_d2 <= tid_d1;
	end

	ack_timing: assert property (@(posedge clk) disable iff (rst) req_cyc |-> ##2 resp_ack)
	else
	begin
		errors++;
		$display("response acknowledge missing two cycles after a request");
	end

	tid_echo: assert property (@(posedge clk) disable iff (rst)
		req_cyc |-> ##2 (resp_tid == tid_d2))
	else
	begin
		errors++;
		$display("FAILED resp_tid: expected %h, got %h", $sampled(tid_d2), $sampled(resp_tid));
	end

	function automatic reg_data_t rand64();
		return {$urandom, $urandom};
	endfunction

	function automatic reg_adr_t region_adr(input int i, input int k);
		return reg_adr_t'(int'(ADR_REGION_BASE) + 4 * i + k);
	endfunction

	function automatic reg_data_t region_word(input int i, input int k);
		case (k)
		0: return m_base[i];
		1: return m_limit[i];
		2: return m_offs[i];
		default: return {63'd0, m_en[i]};  // only the enable bit survives
		endcase
	endfunction

	function automatic reg_data_t fault_info();
		return {m_fault_asid, 47'd0, m_fault_valid};
	endfunction

	function automatic void expect_lookup(input address_t v, output logic hit,
		output region_idx_t idx, output address_t padr);
		hit = 1'b0;
		idx = '0;
		padr = '0;
		for (int i = 0; i < NUM_REGIONS; i++)
			if (!hit && m_en[i] && v >= m_base[i] && v < m_limit[i])
			begin
				hit = 1'b1;
				idx = region_idx_t'(i);
				padr = v - m_base[i] + m_offs[i];
			end
	endfunction

	task automatic model_reset();
		for (int i = 0; i < NUM_REGIONS; i++)
		begin
			m_base[i] = '0;
			m_limit[i] = '0;
			m_offs[i] = '0;
			m_en[i] = 1'b0;
		end
		m_ptbr = '0;
		m_ptattr = '0;
		m_fault_adr = '0;
		m_fault_asid = '0;
		m_fault_valid = 1'b0;
	endtask

	task automatic check_val(input string name, input reg_data_t exp, input reg_data_t act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("FAILED %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic bus_access(input logic we, input reg_adr_t adr, input reg_data_t wdat,
		output reg_data_t rdat);
		int waited;
		@(posedge clk);
		#1;
		req_cyc = 1'b1;
		req_we = we;
		req_adr = adr;
		req_dat = wdat;
		req_tid = tid_t'($urandom);
		@(posedge clk);
		#1;
		req_cyc = 1'b0;
		waited = 0;
		@(negedge clk);
		while (!resp_ack && waited < 8)
		begin
			@(negedge clk);
			waited++;
		end
		rdat = resp_dat;
		if (!resp_ack)
		begin
			errors++;
			$display("no response to the access at address %h", adr);
		end
		trans++;
	endtask

	task automatic write_reg(input reg_adr_t adr, input reg_data_t dat);
		reg_data_t r;
		bus_access(1'b1, adr, dat, r);
		check_val("resp_dat on write", '0, r);
	endtask

	task automatic read_expect(input string name, input reg_adr_t adr, input reg_data_t exp);
		reg_data_t r;
		bus_access(1'b0, adr, '0, r);
		check_val(name, exp, r);
	endtask

	task automatic write_region(input int i, input int k, input reg_data_t w);
		case (k)
		0: m_base[i] = w;
		1: m_limit[i] = w;
		2: m_offs[i] = w;
		default: m_en[i] = w[0];
		endcase
		write_reg(region_adr(i, k), w);
	endtask

	task automatic start_test();
		test_err0 = errors;
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == test_err0)
			$display("test %0d %s: ok", tests, name);
		else
		begin
			failed_tests++;
			$display("test %0d %s: %0d errors", tests, name, errors - test_err0);
		end
	endtask

	task automatic reset_values();
		reg_adr_t adr;
		start_test();
		for (int a = 0; a <= 6; a++)
			read_expect($sformatf("register %02h", a), reg_adr_t'(a), '0);
		for (int a = 16; a < 32; a++)
			read_expect($sformatf("register %02h", a), reg_adr_t'(a), '0);
		check_val("pte_size", reg_data_t'(PTE_4B), reg_data_t'(pte_size));
		for (int n = 0; n < N_UNMAPPED; n++)
		begin
			adr = reg_adr_t'($urandom);
			if (adr <= ADR_PROBE_STAT || (adr >= ADR_REGION_BASE && adr < 8'h20))
				adr = adr + 8'h20;  // move into a hole of the map
			read_expect($sformatf("unmapped %02h", adr), adr, '0);
		end
		finish_test("reset values");
	endtask

	task automatic ptreg_readback();
		reg_data_t v;
		pte_size_e exp_size;
		start_test();
		for (int r = 0; r < N_PT_ROUNDS; r++)
			for (int t = 0; t < 4; t++)
			begin
				m_ptbr = rand64();
				v = rand64();
				m_ptattr = {v[63:2], 2'(t)};
				exp_size = (pt_type_e'(t) == PT_I386) ? PTE_4B : PTE_8B;
				write_reg(ADR_PTBR, m_ptbr);
				write_reg(ADR_PTATTR, m_ptattr);
				check_val("pte_size", reg_data_t'(exp_size), reg_data_t'(pte_size));
				read_expect("PTBR", ADR_PTBR, m_ptbr);
				read_expect("PTATTR", ADR_PTATTR, m_ptattr);
			end
		finish_test("page table registers");
	endtask

	task automatic region_readback();
		start_test();
		for (int r = 0; r < N_TBL_ROUNDS; r++)
		begin
			for (int i = 0; i < NUM_REGIONS; i++)
				for (int k = 0; k < 4; k++)
					write_region(i, k, rand64());
			for (int i = 0; i < NUM_REGIONS; i++)
				for (int k = 0; k < 4; k++)
					read_expect($sformatf("region %0d word %0d", i, k), region_adr(i, k),
						region_word(i, k));
		end
		finish_test("region table");
	endtask

	task automatic probe_check(input address_t v);
		logic hit;
		region_idx_t idx;
		address_t padr;
		expect_lookup(v, hit, idx, padr);
		write_reg(ADR_PROBE_VADR, v);
		repeat (3) @(posedge clk);
		read_expect("PROBE_VADR", ADR_PROBE_VADR, v);
		read_expect("PROBE_PADR", ADR_PROBE_PADR, padr);
		read_expect("PROBE_STAT", ADR_PROBE_STAT, {54'd0, idx, 7'd0, hit});
	endtask

	task automatic probe_lookups();
		address_t size [NUM_REGIONS];
		start_test();
		for (int s = 0; s < N_SETUPS; s++)
		begin
			for (int i = 0; i < NUM_REGIONS - 1; i++)
			begin
				size[i] = 64'(($urandom % 32) + 1) * 64'h1000;
				write_region(i, 0, 64'(($urandom % 64) + 1) * 64'h1000);
				write_region(i, 1, m_base[i] + size[i]);
				write_region(i, 2, rand64());
				write_region(i, 3, reg_data_t'(($urandom % 4) != 0));
			end
			// last region overlaps the upper half of region 1
			write_region(3, 0, m_base[1] + (size[1] >> 1));
			write_region(3, 1, m_limit[1] + 64'h2000);
			write_region(3, 2, rand64());
			write_region(3, 3, 64'd1);
			size[3] = m_limit[3] - m_base[3];
			for (int i = 0; i < NUM_REGIONS; i++)
			begin
				probe_check(m_base[i] + (rand64() % size[i]));
				probe_check(m_base[i] - 64'd1);
				probe_check(m_limit[i]);
			end
			probe_check(m_base[3]);
		end
		finish_test("probe lookups");
	endtask

	task automatic drive_fault(input address_t v, input asid_t a);
		@(posedge clk);
		#1;
		fault_stb = 1'b1;
		fault_vadr = v;
		fault_asid = a;
		if (!m_fault_valid)
		begin
			m_fault_valid = 1'b1;
			m_fault_adr = v;
			m_fault_asid = a;
		end
	endtask

	task automatic stop_fault();
		@(posedge clk);
		#1;
		fault_stb = 1'b0;
	endtask

	task automatic fault_latching();
		start_test();
		drive_fault(rand64(), asid_t'($urandom));
		drive_fault(rand64(), asid_t'($urandom));  // second strobe must be ignored
		stop_fault();
		read_expect("FAULT_ADR", ADR_FAULT_ADR, m_fault_adr);
		read_expect("FAULT_INFO", ADR_FAULT_INFO, fault_info());
		write_reg(ADR_FAULT_INFO, rand64());
		m_fault_valid = 1'b0;
		read_expect("FAULT_INFO", ADR_FAULT_INFO, fault_info());
		drive_fault(rand64(), asid_t'($urandom));
		stop_fault();
		read_expect("FAULT_ADR", ADR_FAULT_ADR, m_fault_adr);
		read_expect("FAULT_INFO", ADR_FAULT_INFO, fault_info());
		finish_test("fault latch");
	endtask

	initial
	begin
		void'($urandom(36463));
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		trans = 0;
		test_err0 = 0;
		rst = 1'b1;
		req_cyc = 1'b0;
		req_we = 1'b0;
		req_adr = '0;
		req_dat = '0;
		req_tid = '0;
		fault_stb = 1'b0;
		fault_vadr = '0;
		fault_asid = '0;
		model_reset();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		reset_values();
		ptreg_readback();
		region_readback();
		probe_lookups();
		fault_latching();

		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d transactions",
			tests, failed_tests, checks, errors, trans);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* mmu_regs.f */
hdl/mmu_pkg.sv
hdl/mmu_reg_bus_if.sv
hdl/mmu_reg_ctrl.sv
hdl/mmu_read_reg.sv
hdl/mmu_fault_capture.sv
hdl/mmu_region_table.sv
hdl/mmu_regs.sv
test/tb_mmu_regs.sv

/* Makefile */
# Verilator build and run of the MMU register block testbench

TOP = tb_mmu_regs

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f mmu_regs.f -o V$(TOP)

# the log decides the outcome
run: compile
	rm -f sim.log
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "^Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
